// ==== project.f ====
+incdir+rtl
rtl/flow_pkg.sv
rtl/flow_reg_fwd.sv
rtl/flow_demux_select.sv
rtl/flow_fifo.sv
rtl/flow_demux_pipe.sv
sim/tb_flow_demux_pipe.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
# The result comes from the simulation log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir

verilator --binary --assert --timescale 1ns/1ps -f project.f \
  --top-module tb_flow_demux_pipe > build.log 2>&1 \
  && ./obj_dir/Vtb_flow_demux_pipe > "$LOG" 2>&1 \
  || { echo "Build or run error, see build.log and $LOG"; exit 1; }

grep -qx "Simulation finished: PASS" "$LOG" \
  && { echo "Test passed"; exit 0; } \
  || { echo "Test failed, see $LOG"; exit 1; }

// ==== sim/tb_flow_demux_pipe.sv ====
// Testbench for the flow demux pipeline
// Drives random items through the DUT and checks routing, order, latency and
// head-of-line blocking against per-flow reference queues

`timescale 1ns/1ps

`include "flow_defs.svh"

module tb_flow_demux_pipe;

  import flow_pkg::*;

  localparam int SEL_W       = $bits(flow_sel_t);
  localparam int PUSH_LIMIT  = 100;
  localparam int DRAIN_LIMIT = 500;
  localparam int HOLD_CYCLES = 8;

  // Ways of driving the pop ready vector
  localparam int MODE_ALL    = 0;
  localparam int MODE_RANDOM = 1;
  localparam int MODE_FIXED  = 2;

  logic                       clk;
  logic                       rst_n;
  logic                       push_valid;
  logic                       push_ready;
  flow_sel_t                  push_sel;
  flow_data_t                 push_data;
  flow_mask_t                 pop_ready;
  flow_mask_t                 pop_valid;
  flow_data_t [`FLOW_NUM-1:0] pop_data;

  // Expected items per flow, in push order
  flow_data_t exp_data  [`FLOW_NUM][$];
  int         exp_cycle [`FLOW_NUM][$];
  int         delivered [`FLOW_NUM];

  int          cycle_no;
  int          ready_mode;
  flow_mask_t  ready_fixed;
  logic        latency_check;
  logic [15:0] lfsr_state = 16'd98;

  int err_data;
  int err_flow;
  int err_ctrl;
  int err_other;

  flow_demux_pipe DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_sel  (push_sel),
    .push_data (push_data),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .pop_data  (pop_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------
  // Random numbers and reference
  // ----------------------------------------

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic flow_sel_t rand_flow();
    return flow_sel_t'(take_bits(SEL_W) % `FLOW_NUM);
  endfunction

  // An item belongs to the flow its select names
  function automatic flow_sel_t expected_flow(input flow_sel_t sel, input flow_data_t data);
    return sel;
  endfunction

  // Flow whose oldest pending item carries this payload
  // Falls back to the popping flow when no queue head matches
  function automatic flow_sel_t owner_flow(input int flow, input flow_data_t data);
    flow_sel_t owner;
    owner = flow_sel_t'(flow);
    if (!(exp_data[flow].size() != 0 && exp_data[flow][0] == data)) begin
      for (int f = 0; f < `FLOW_NUM; f++) begin
        if (exp_data[f].size() != 0 && exp_data[f][0] == data) begin
          owner = flow_sel_t'(f);
        end
      end
    end
    return owner;
  endfunction

  function automatic int pending();
    int total;
    total = 0;
    for (int i = 0; i < `FLOW_NUM; i++) begin
      total += exp_data[i].size();
    end
    return total;
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_data(input string name, input flow_data_t exp, input flow_data_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
      err_data++;
    end
  endtask

  task automatic check_flow(input string name, input flow_sel_t exp, input flow_sel_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
      err_flow++;
    end
  endtask

  task automatic check_mask(input string name, input flow_mask_t exp, input flow_mask_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
      err_ctrl++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
      err_ctrl++;
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("CHECK FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
      err_ctrl++;
    end
  endtask

  // ----------------------------------------
  // Monitor and compare process
  // ----------------------------------------

  always @(posedge clk) begin : monitor
    flow_sel_t  want_flow;
    flow_data_t want_data;
    int         push_cycle;
    if (rst_n) begin
      cycle_no = cycle_no + 1;
      for (int i = 0; i < `FLOW_NUM; i++) begin
        if (pop_valid[i] && pop_ready[i]) begin
          // Item must come out on the flow it was queued for
          want_flow = owner_flow(i, pop_data[i]);
          check_flow($sformatf("flow of pop_data[%0d]", i), want_flow, flow_sel_t'(i));
          if (exp_data[i].size() == 0) begin
            $display("ERROR: flow %0d delivered an item that was never sent to it", i);
            err_other++;
          end else begin
            want_data  = exp_data[i].pop_front();
            push_cycle = exp_cycle[i].pop_front();
            check_data($sformatf("pop_data[%0d]", i), want_data, pop_data[i]);
            // Input register plus registered FIFO output
            if (latency_check) begin
              check_latency($sformatf("latency on flow %0d", i), 2, cycle_no - push_cycle);
            end
            delivered[i] = delivered[i] + 1;
          end
        end
      end
      // Record each accepted item in its flow's queue
      if (push_valid && push_ready) begin
        want_flow = expected_flow(push_sel, push_data);
        exp_data[want_flow].push_back(push_data);
        exp_cycle[want_flow].push_back(cycle_no);
      end
    end
  end

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------

  // New pop ready vector for the coming cycle
  task automatic set_ready();
    case (ready_mode)
      MODE_ALL:    pop_ready = '1;
      MODE_RANDOM: pop_ready = flow_mask_t'(take_bits(`FLOW_NUM));
      default:     pop_ready = ready_fixed;
    endcase
  endtask

  // One clock; reports whether the push was taken at the rising edge
  task automatic tick(output logic took);
    @(posedge clk);
    took = push_valid && push_ready;
    @(negedge clk);
    set_ready();
  endtask

  task automatic send_item(input flow_sel_t sel, input flow_data_t data);
    logic took;
    int   waited;
    push_valid = 1'b1;
    push_sel   = sel;
    push_data  = data;
    took       = 1'b0;
    waited     = 0;
    while (!took && waited < PUSH_LIMIT) begin
      tick(took);
      waited++;
    end
    if (!took) begin
      $display("ERROR: item for flow %0d not accepted within %0d cycles", sel, PUSH_LIMIT);
      err_other++;
    end
    push_valid = 1'b0;
  endtask

  task automatic send_random(input logic gaps);
    flow_sel_t  sel;
    flow_data_t data;
    logic       took;
    // Idle cycle about one time in four
    if (gaps && take_bits(2) == 0) begin
      tick(took);
    end
    sel  = rand_flow();
    data = flow_data_t'(take_bits(`FLOW_DATA_W));
    send_item(sel, data);
  endtask

  task automatic wait_drained(input string phase);
    logic took;
    int   waited;
    waited = 0;
    while (pending() != 0 && waited < DRAIN_LIMIT) begin
      tick(took);
      waited++;
    end
    if (pending() != 0) begin
      $display("ERROR: %s phase left %0d items undelivered after %0d cycles",
               phase, pending(), DRAIN_LIMIT);
      err_other++;
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin : stimulus
    logic       took;
    int         waited;
    flow_sel_t  k;
    flow_sel_t  j;
    int         before_j;
    int         before_k;
    rst_n         = 1'b0;
    push_valid    = 1'b0;
    push_sel      = '0;
    push_data     = '0;
    pop_ready     = '1;
    ready_mode    = MODE_ALL;
    ready_fixed   = '1;
    latency_check = 1'b0;
    cycle_no      = 0;
    err_data      = 0;
    err_flow      = 0;
    err_ctrl      = 0;
    err_other     = 0;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle state straight out of reset
    check_mask("pop_valid", '0, pop_valid);
    check_bit("push_ready", 1'b1, push_ready);

    // Back to back items with every flow ready
    latency_check = 1'b1;
    for (int n = 0; n < 40; n++) begin
      send_random(1'b0);
    end
    wait_drained("routing");
    latency_check = 1'b0;

    // Random select, gaps and back-pressure
    ready_mode = MODE_RANDOM;
    for (int n = 0; n < 200; n++) begin
      send_random(1'b1);
    end
    ready_mode = MODE_ALL;
    wait_drained("random");

    // Block one flow and fill its FIFO plus the input register
    k           = rand_flow();
    j           = flow_sel_t'((int'(k) + 1) % `FLOW_NUM);
    before_k    = delivered[k];
    before_j    = delivered[j];
    ready_fixed = '1;
    ready_fixed[k] = 1'b0;
    ready_mode  = MODE_FIXED;
    pop_ready   = ready_fixed;
    for (int n = 0; n < `FLOW_FIFO_DEPTH + 1; n++) begin
      send_item(k, flow_data_t'(take_bits(`FLOW_DATA_W)));
    end
    check_bit("push_ready", 1'b0, push_ready);
    check_bit("pop_valid of blocked flow", 1'b1, pop_valid[k]);

    // Item for another flow waits behind the blocked one
    push_valid = 1'b1;
    push_sel   = j;
    push_data  = flow_data_t'(take_bits(`FLOW_DATA_W));
    for (int c = 0; c < HOLD_CYCLES; c++) begin
      tick(took);
      if (took) begin
        $display("ERROR: input accepted an item while flow %0d was full", k);
        err_other++;
      end
    end
    if (delivered[j] != before_j || delivered[k] != before_k) begin
      $display("ERROR: an item was delivered while flow %0d was blocked", k);
      err_other++;
    end

    // Release the blocked flow and let the held item through
    ready_mode = MODE_ALL;
    pop_ready  = '1;
    took       = 1'b0;
    waited     = 0;
    while (!took && waited < PUSH_LIMIT) begin
      tick(took);
      waited++;
    end
    push_valid = 1'b0;
    if (!took) begin
      $display("ERROR: held item for flow %0d never accepted after release", j);
      err_other++;
    end
    waited = 0;
    while (delivered[j] == before_j && waited < PUSH_LIMIT) begin
      tick(took);
      waited++;
    end
    if (delivered[j] == before_j) begin
      $display("ERROR: held item for flow %0d never delivered", j);
      err_other++;
    end else if (delivered[k] == before_k) begin
      $display("ERROR: item for flow %0d overtook the blocked flow %0d", j, k);
      err_other++;
    end
    wait_drained("blocking");
    if (delivered[k] - before_k != `FLOW_FIFO_DEPTH + 1) begin
      $display("ERROR: blocked flow %0d delivered %0d items instead of %0d",
               k, delivered[k] - before_k, `FLOW_FIFO_DEPTH + 1);
      err_other++;
    end

    wait_drained("final");
    $display("Errors: data %0d, flow %0d, control %0d, other %0d",
             err_data, err_flow, err_ctrl, err_other);
    if (err_data + err_flow + err_ctrl + err_other == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== rtl/flow_demux_pipe.sv ====
// Top of the flow router: input register, select demux, one FIFO per flow
// Items keep push order within a flow; a full FIFO stalls the whole input,
// so later items for other flows wait behind it

`timescale 1ns/1ps

`include "flow_defs.svh"

module flow_demux_pipe (
  input  logic                                 clk,
  input  logic                                 rst_n,

  // Input stream with destination select
  input  logic                                 push_valid,
  output logic                                 push_ready,
  input  flow_pkg::flow_sel_t                  push_sel,
  input  flow_pkg::flow_data_t                 push_data,

  // Output streams, one per flow
  input  flow_pkg::flow_mask_t                 pop_ready,
  output flow_pkg::flow_mask_t                 pop_valid,
  output flow_pkg::flow_data_t [`FLOW_NUM-1:0] pop_data
);

  import flow_pkg::*;

  localparam int SEL_W  = $bits(flow_sel_t);
  localparam int WORD_W = SEL_W + `FLOW_DATA_W;

  // ----------------------------------------
  // Input stage
  // ----------------------------------------

  // Select rides in the upper bits of the register word
  logic [WORD_W-1:0] in_word;
  logic [WORD_W-1:0] reg_word;
  logic              reg_valid;
  logic              reg_ready;
  flow_sel_t         reg_sel;
  flow_data_t        reg_data;

  assign in_word = {push_sel, push_data};

  flow_reg_fwd #(
    .WIDTH(WORD_W)
  ) u_in_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_data (in_word),
    .pop_valid (reg_valid),
    .pop_ready (reg_ready),
    .pop_data  (reg_word)
  );

  // Split the held word back into select and payload
  assign reg_sel  = reg_word[WORD_W-1 -: SEL_W];
  assign reg_data = reg_word[`FLOW_DATA_W-1:0];

  // ----------------------------------------
  // Demux
  // ----------------------------------------

  flow_mask_t                  dmx_valid;
  flow_mask_t                  dmx_ready;
  flow_data_t [`FLOW_NUM-1:0]  dmx_data;

  flow_demux_select u_demux (
    .clk       (clk),
    .rst_n     (rst_n),
    .select    (reg_sel),
    .push_valid(reg_valid),
    .push_ready(reg_ready),
    .push_data (reg_data),
    .pop_ready (dmx_ready),
    .pop_valid (dmx_valid),
    .pop_data  (dmx_data)
  );

  // ----------------------------------------
  // Per-flow buffering
  // ----------------------------------------

  for (genvar i = 0; i < `FLOW_NUM; i++) begin : g_flow
    flow_fifo u_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .push_valid(dmx_valid[i]),
      .push_ready(dmx_ready[i]),
      .push_data (dmx_data[i]),
      .pop_valid (pop_valid[i]),
      .pop_ready (pop_ready[i]),
      .pop_data  (pop_data[i])
    );
  end

endmodule

// ==== rtl/flow_fifo.sv ====
// Ready-valid FIFO for one output flow, with a registered output stage
// The output register counts as one of the FLOW_FIFO_DEPTH entries and
// fills directly from the push side when the FIFO is empty

`timescale 1ns/1ps

`include "flow_defs.svh"

module flow_fifo (
  input  logic                 clk,
  input  logic                 rst_n,

  // Write side
  input  logic                 push_valid,
  output logic                 push_ready,
  input  flow_pkg::flow_data_t push_data,

  // Read side, driven straight from a register
  output logic                 pop_valid,
  input  logic                 pop_ready,
  output flow_pkg::flow_data_t pop_data
);

  import flow_pkg::*;

  localparam int DEPTH = `FLOW_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // ----------------------------------------
  // State
  // ----------------------------------------

  // Backing store for items behind the output register
  // At most DEPTH-1 slots are ever in use
  flow_data_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  // Items held in total, output register included
  logic [CNT_W-1:0] count;

  // Items sitting in the backing store only
  logic [CNT_W-1:0] stored;

  logic             full;
  logic             do_push;
  logic             do_pop;
  logic             out_load;
  logic             mem_empty;
  logic             mem_wr;
  logic             mem_rd;

  // ----------------------------------------
  // Control
  // ----------------------------------------

  assign full = (count == CNT_W'(DEPTH));

  // Full blocks a push unless the head leaves in the same cycle
  assign push_ready = !full || pop_ready;

  assign do_push = push_valid && push_ready;
  assign do_pop  = pop_valid && pop_ready;

  assign stored    = count - CNT_W'(pop_valid);
  assign mem_empty = (stored == '0);

  // Output register takes a new word when empty or draining
  assign out_load = !pop_valid || pop_ready;

  // Head refills from the store first, to keep order
  assign mem_rd = out_load && !mem_empty;

  // Pushed word bypasses the store only if the store is empty and the head is free
  assign mem_wr = do_push && !(out_load && mem_empty);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      pop_valid <= 1'b0;
    end else begin
      // Pointers wrap on their own since DEPTH is a power of two
      if (mem_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (!do_push && do_pop) begin
        count <= count - 1'b1;
      end
      // Head stays valid if anything can refill it
      if (out_load) begin
        pop_valid <= !mem_empty || do_push;
      end
    end
  end

  // ----------------------------------------
  // Datapath
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= push_data;
    end
    // Refill from the store, or bypass the pushed word
    if (mem_rd) begin
      pop_data <= mem[rd_ptr];
    end else if (out_load && do_push) begin
      pop_data <= push_data;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // A push into a full FIFO is legal only with a pop alongside
  a_no_write_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    (do_push && full) |-> do_pop
  ) else $error("flow_fifo: write while full");

  // A pop needs at least one item on record
  a_no_read_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    do_pop |-> (count != '0)
  ) else $error("flow_fifo: read while empty");

  a_count_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= CNT_W'(DEPTH)
  ) else $error("flow_fifo: count %0d above depth", count);

endmodule

// ==== rtl/flow_demux_select.sv ====
// Combinational ready-valid demux steered by an explicit select
// Select must stay stable while push_valid is high and the push stalls,
// so place a holding register such as flow_reg_fwd in front of it

`timescale 1ns/1ps

`include "flow_defs.svh"

module flow_demux_select (
  // Clock and reset feed the checks only
  input  logic                                  clk,
  input  logic                                  rst_n,

  // Destination of the current item
  input  flow_pkg::flow_sel_t                   select,

  // Single input stream
  input  logic                                  push_valid,
  output logic                                  push_ready,
  input  flow_pkg::flow_data_t                  push_data,

  // One output stream per flow
  input  flow_pkg::flow_mask_t                  pop_ready,
  output flow_pkg::flow_mask_t                  pop_valid,
  output flow_pkg::flow_data_t [`FLOW_NUM-1:0]  pop_data
);

  import flow_pkg::*;

  // ----------------------------------------
  // Steering
  // ----------------------------------------

  // Input is ready exactly when the chosen output is
  assign push_ready = pop_ready[select];

  // Valid lands on the selected bit only, all others stay low
  assign pop_valid = flow_mask_t'(push_valid) << select;

  // Same payload on every output
  // Outputs whose valid is low simply ignore it
  always_comb begin
    for (int i = 0; i < `FLOW_NUM; i++) begin
      pop_data[i] = push_data;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // A live item must name an existing flow
  a_select_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    push_valid |-> (select < `FLOW_NUM)
  ) else $error("flow_demux_select: select %0d out of range", select);

  // Upstream must keep select steady while the item waits
  a_select_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (push_valid && !push_ready) |=> $stable(select)
  ) else $error("flow_demux_select: select changed under stall");

endmodule

// ==== rtl/flow_reg_fwd.sv ====
// One-entry ready-valid pipeline register with full throughput
// Holds its word stable while the consumer stalls, so select bits carried in the
// word stay stable for a combinational demux behind it

`timescale 1ns/1ps

module flow_reg_fwd #(
  // Bits in the carried word
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,

  // Upstream side
  input  logic             push_valid,
  output logic             push_ready,
  input  logic [WIDTH-1:0] push_data,

  // Downstream side
  output logic             pop_valid,
  input  logic             pop_ready,
  output logic [WIDTH-1:0] pop_data
);

  // ----------------------------------------
  // Handshake
  // ----------------------------------------

  logic push_xfer;

  // Accept when empty, or when the held item leaves this same cycle
  // This keeps one item per cycle in steady state
  assign push_ready = !pop_valid || pop_ready;

  assign push_xfer = push_valid && push_ready;

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  // Valid bit follows the upstream valid whenever a slot opens up
  // A drain with no new item leaves the register empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pop_valid <= 1'b0;
    end else if (push_ready) begin
      pop_valid <= push_valid;
    end
  end

  // Payload only moves on an accepted push
  // Stalled cycles keep the old word, select bits included
  always_ff @(posedge clk) begin
    if (push_xfer) begin
      pop_data <= push_data;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // A stalled item must not vanish or change
  // The demux downstream relies on this for a stable select
  a_hold_under_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_data))
  ) else $error("flow_reg_fwd: output changed while stalled");

endmodule

// ==== rtl/flow_pkg.sv ====
// Shared vector types for the flow demux pipeline
// Modules import this package in their bodies and use scoped names in their ports

package flow_pkg;

`include "flow_defs.svh"

  // ----------------------------------------
  // Item fields
  // ----------------------------------------

  // One payload word
  typedef logic [`FLOW_DATA_W-1:0] flow_data_t;

  // Destination index of an item
  // Wide enough to name every flow
  typedef logic [$clog2(`FLOW_NUM)-1:0] flow_sel_t;

  // ----------------------------------------
  // Per-flow vectors
  // ----------------------------------------

  // One bit per output flow
  // Carries the pop valid and pop ready vectors
  typedef logic [`FLOW_NUM-1:0] flow_mask_t;

endpackage

// ==== rtl/flow_defs.svh ====
// Width, flow count and FIFO depth for the flow demux pipeline
// Included by the package and by every RTL module that sizes a port or array
// Edit the values here to resize the whole design

`ifndef FLOW_DEFS_SVH
`define FLOW_DEFS_SVH

// ----------------------------------------
// Payload
// ----------------------------------------

// Bits of payload carried per item
`define FLOW_DATA_W 16

// ----------------------------------------
// Topology and buffering
// ----------------------------------------

// Number of output flows, at least 2
`define FLOW_NUM 4

// Entries per output FIFO, counting the output register
// Power of two, at least 2
`define FLOW_FIFO_DEPTH 4

`endif
